// ==== project.f ====
+incdir+rtl
rtl/des_pkg.sv
rtl/des_ctrl.sv
rtl/des_key_sched.sv
rtl/des_round_f.sv
rtl/des_block_path.sv
rtl/des_core.sv
verif/des_tb.sv

// ==== verif/des_tb.sv ====
`timescale 1ns/1ps
`include "des_settings.svh"

module des_tb;

  localparam int N_VEC       = 6;
  localparam int N_RT        = 20;
  localparam int OP_CYCLES   = `DES_ROUNDS + 4;
  localparam int N_OPS       = N_VEC + 2 * N_RT + 1;
  localparam int CYCLE_LIMIT = N_OPS * OP_CYCLES + 16 + 200;

  // known answers: mode, key, input block, expected output
  localparam logic VEC_DEC [0:N_VEC-1] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
  localparam logic [63:0] VEC_KEY [0:N_VEC-1] = '{
    64'h133457799BBCDFF1, 64'h0E329232EA6D0D73, 64'h0000000000000000,
    64'h133457799BBCDFF1, 64'h0E329232EA6D0D73, 64'h0000000000000000};
  localparam logic [63:0] VEC_IN [0:N_VEC-1] = '{
    64'h0123456789ABCDEF, 64'h8787878787878787, 64'h0000000000000000,
    64'h85E813540F0AB405, 64'h0000000000000000, 64'h8CA64DE9C1B123A7};
  localparam logic [63:0] VEC_EXP [0:N_VEC-1] = '{
    64'h85E813540F0AB405, 64'h0000000000000000, 64'h8CA64DE9C1B123A7,
    64'h0123456789ABCDEF, 64'h8787878787878787, 64'h0000000000000000};

  logic            clk;
  logic            rst;
  logic            start;
  logic            decrypt;
  des_pkg::block_t block_in;
  des_pkg::block_t key_in;
  logic            busy;
  logic            done;
  des_pkg::block_t block_out;

  int              cycle_cnt;
  int unsigned     seed_dummy;
  logic [63:0]     res;
  logic [63:0]     ct;
  logic [63:0]     pt;
  logic [63:0]     rkey;
  logic [63:0]     rblk;

  des_core dut0 (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .decrypt   (decrypt),
    .block_in  (block_in),
    .key_in    (key_in),
    .busy      (busy),
    .done      (done),
    .block_out (block_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // limit sized from the number of blocks run
  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("simulation ran past %0d cycles without finishing", CYCLE_LIMIT);
    $display(">>> FAIL");
    $fatal(1, "timeout waiting for the DUT");
  end

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // one block start to done, optional second start while busy
  task automatic run_block(input logic dec, input logic [63:0] key, input logic [63:0] blk,
                           input logic inject, input int hold, output logic [63:0] result);
    int   edges;
    logic seen_done;
    @(posedge clk);
    start    <= 1'b1;
    decrypt  <= dec;
    key_in   <= key;
    block_in <= blk;
    @(posedge clk);
    start     <= 1'b0;
    edges     = 0;
    seen_done = 1'b0;
    while (!seen_done) begin
      @(negedge clk);
      if (done) begin
        seen_done = 1'b1;
      end else begin
        compare_value("busy", busy, 1);
        @(posedge clk);
        edges++;
        start <= 1'b0;
        if (inject && edges == 6) begin
          start    <= 1'b1;
          decrypt  <= ~dec;
          key_in   <= ~key;
          block_in <= ~blk;
        end
      end
    end
    compare_value("done_latency", edges, `DES_ROUNDS + 1);
    result = block_out;
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      compare_value("done", done, 0);
      compare_value("busy", busy, 0);
      compare_value("block_out", block_out, result);
    end
  endtask

  initial begin
    rst      = 1'b1;
    start    = 1'b0;
    decrypt  = 1'b0;
    block_in = '0;
    key_in   = '0;
    seed_dummy = $urandom(32'h136f);

    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    compare_value("busy", busy, 0);
    compare_value("done", done, 0);

    for (int i = 0; i < N_VEC; i++) begin
      run_block(VEC_DEC[i], VEC_KEY[i], VEC_IN[i], 1'b0, 1, res);
      compare_value("block_out", res, VEC_EXP[i]);
    end

    // encrypt then decrypt under the same key
    for (int i = 0; i < N_RT; i++) begin
      rkey = {$urandom, $urandom};
      rblk = {$urandom, $urandom};
      run_block(1'b0, rkey, rblk, 1'b0, 1, ct);
      run_block(1'b1, rkey, ct, 1'b0, 1, pt);
      compare_value("block_out", pt, rblk);
    end

    // second start mid-block must be dropped
    run_block(VEC_DEC[0], VEC_KEY[0], VEC_IN[0], 1'b1, 8, res);
    compare_value("block_out", res, VEC_EXP[0]);

    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== rtl/des_core.sv ====
`timescale 1ns/1ps

module des_core (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  input  logic            decrypt,
  input  des_pkg::block_t block_in,
  input  des_pkg::block_t key_in,
  output logic            busy,
  output logic            done,
  output des_pkg::block_t block_out
);

  logic             load;
  logic             round_en;
  des_pkg::round_t  round;
  des_pkg::subkey_t subkey;
  des_pkg::half_t   f_out;
  des_pkg::half_t   right;

  des_ctrl u_ctrl (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .load     (load),
    .round_en (round_en),
    .busy     (busy),
    .done     (done),
    .round    (round)
  );

  des_key_sched u_key_sched (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .load     (load),
    .round_en (round_en),
    .decrypt  (decrypt),
    .key_in   (key_in),
    .round    (round),
    .subkey   (subkey)
  );

  des_round_f u_round_f (
    .right  (right),
    .subkey (subkey),
    .f_out  (f_out)
  );

  des_block_path u_block_path (
    .clk       (clk),
    .rst       (rst),
    .load      (load),
    .round_en  (round_en),
    .block_in  (block_in),
    .f_out     (f_out),
    .right     (right),
    .block_out (block_out)
  );

endmodule

// ==== rtl/des_block_path.sv ====
`timescale 1ns/1ps
`include "des_settings.svh"

module des_block_path (
  input  logic            clk,
  input  logic            rst,
  input  logic            load,
  input  logic            round_en,
  input  des_pkg::block_t block_in,
  input  des_pkg::half_t  f_out,
  output des_pkg::half_t  right,
  output des_pkg::block_t block_out
);

  des_pkg::half_t  l_q;
  des_pkg::half_t  r_q;
  des_pkg::block_t ip_blk;
  des_pkg::block_t pre_out;

  always_comb begin
    for (int i = 1; i <= `DES_BLOCK_W; i++) begin
      ip_blk[i] = block_in[des_pkg::IP_TAB[i]];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      l_q <= '0;
      r_q <= '0;
    end else if (load) begin
      l_q <= ip_blk[1:`DES_HALF_W];
      r_q <= ip_blk[`DES_HALF_W+1:`DES_BLOCK_W];
    end else if (round_en) begin
      l_q <= r_q;
      r_q <= l_q ^ f_out;
    end
  end

  assign right = r_q;

  // halves swap once more before the final permutation
  assign pre_out = {r_q, l_q};

  always_comb begin
    for (int i = 1; i <= `DES_BLOCK_W; i++) begin
      block_out[i] = pre_out[des_pkg::FP_TAB[i]];
    end
  end

endmodule

// ==== rtl/des_round_f.sv ====
`timescale 1ns/1ps
`include "des_settings.svh"

module des_round_f (
  input  des_pkg::half_t   right,
  input  des_pkg::subkey_t subkey,
  output des_pkg::half_t   f_out
);

  logic [1:`DES_SUBKEY_W] x_mix;
  logic [1:`DES_HALF_W]   s_out;

  // expansion then key mixing
  always_comb begin
    for (int i = 1; i <= `DES_SUBKEY_W; i++) begin
      x_mix[i] = right[des_pkg::E_TAB[i]] ^ subkey[i];
    end
  end

  always_comb begin : sbox_lookup
    logic [5:0] grp;
    for (int s = 0; s < 8; s++) begin
      grp = x_mix[6*s+1 +: 6];
      // outer bits pick the row, inner four the column
      s_out[4*s+1 +: 4] = des_pkg::SBOX_TAB[s+1][{grp[5], grp[0], grp[4:1]}];
    end
  end

  always_comb begin
    for (int i = 1; i <= `DES_HALF_W; i++) begin
      f_out[i] = s_out[des_pkg::P_TAB[i]];
    end
  end

endmodule

// ==== rtl/des_key_sched.sv ====
`timescale 1ns/1ps
`include "des_settings.svh"

module des_key_sched (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  logic             load,
  input  logic             round_en,
  input  logic             decrypt,
  input  des_pkg::block_t  key_in,
  input  des_pkg::round_t  round,
  output des_pkg::subkey_t subkey
);

  logic [1:`DES_CD_W]   c_q;
  logic [1:`DES_CD_W]   d_q;
  logic [1:`DES_CD_W]   c_nxt;
  logic [1:`DES_CD_W]   d_nxt;
  logic [1:2*`DES_CD_W] cd_nxt;
  logic                 rot_left;
  logic [1:0]           rot_n;
  des_pkg::des_mode_e   mode_q;

  function automatic logic [1:2*`DES_CD_W] pc1(input logic [1:`DES_KEY_W] k);
    logic [1:2*`DES_CD_W] y;
    for (int i = 1; i <= 2 * `DES_CD_W; i++) begin
      y[i] = k[des_pkg::PC1_TAB[i]];
    end
    return y;
  endfunction

  function automatic logic [1:`DES_CD_W] rotate(input logic [1:`DES_CD_W] x,
                                                input logic left,
                                                input logic [1:0] n);
    logic [1:`DES_CD_W] y;
    y = x;
    for (int k = 0; k < 2; k++) begin
      if (k < n) begin
        y = left ? {y[2:`DES_CD_W], y[1]} : {y[`DES_CD_W], y[1:`DES_CD_W-1]};
      end
    end
    return y;
  endfunction

  // decrypt walks the encrypt schedule backwards from C16/D16
  always_comb begin
    rot_left = (mode_q == des_pkg::MODE_ENC);
    rot_n    = 2'd0;
    if (round >= 1 && round <= `DES_ROUNDS) begin
      if (rot_left) begin
        rot_n = des_pkg::SHIFT_TAB[round];
      end else if (round != 1) begin
        rot_n = des_pkg::SHIFT_TAB[`DES_ROUNDS + 2 - round];
      end
    end
  end

  assign c_nxt  = rotate(c_q, rot_left, rot_n);
  assign d_nxt  = rotate(d_q, rot_left, rot_n);
  assign cd_nxt = {c_nxt, d_nxt};

  always_comb begin
    for (int i = 1; i <= `DES_SUBKEY_W; i++) begin
      subkey[i] = cd_nxt[des_pkg::PC2_TAB[i]];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mode_q <= des_pkg::MODE_ENC;
    end else if (load) begin
      mode_q <= decrypt ? des_pkg::MODE_DEC : des_pkg::MODE_ENC;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      {c_q, d_q} <= pc1(key_in);
    end else if (round_en) begin
      c_q <= c_nxt;
      d_q <= d_nxt;
    end
  end

  a_mode_stable: assert property (@(posedge clk) disable iff (rst) round_en |=> $stable(mode_q))
    else $error("mode changed in the middle of a block");

endmodule

// ==== rtl/des_ctrl.sv ====
`timescale 1ns/1ps
`include "des_settings.svh"

module des_ctrl (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  output logic            load,
  output logic            round_en,
  output logic            busy,
  output logic            done,
  output des_pkg::round_t round
);

  des_pkg::ctrl_state_e state_q;
  des_pkg::round_t      round_q;

  // a start only counts while idle
  assign load     = start && (state_q == des_pkg::IDLE);
  assign round_en = (state_q == des_pkg::ROUND);
  assign busy     = (state_q != des_pkg::IDLE);
  assign round    = round_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= des_pkg::IDLE;
      round_q <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state_q)
        des_pkg::IDLE: begin
          if (start) begin
            state_q <= des_pkg::ROUND;
            round_q <= des_pkg::round_t'(1);
          end
        end
        des_pkg::ROUND: begin
          if (round_q == `DES_ROUNDS) begin
            state_q <= des_pkg::DONE;
            round_q <= '0;
          end else begin
            round_q <= round_q + des_pkg::round_t'(1);
          end
        end
        des_pkg::DONE: begin
          // result already settled, report it one cycle later
          state_q <= des_pkg::IDLE;
          done    <= 1'b1;
        end
        default: begin
          state_q <= des_pkg::IDLE;
        end
      endcase
    end
  end

  a_done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("done held for more than one cycle");

  a_round_range: assert property (@(posedge clk) disable iff (rst)
    round_en |-> (round_q >= 1 && round_q <= `DES_ROUNDS))
    else $error("round counter out of range during a round");

endmodule

// ==== rtl/des_pkg.sv ====
`include "des_settings.svh"

package des_pkg;

  typedef enum logic [1:0] {IDLE, ROUND, DONE} ctrl_state_e;
  typedef enum logic {MODE_ENC, MODE_DEC} des_mode_e;

  // bit 1 is the msb, as in the standard
  typedef logic [1:`DES_BLOCK_W]  block_t;
  typedef logic [1:`DES_HALF_W]   half_t;
  typedef logic [1:`DES_SUBKEY_W] subkey_t;
  typedef logic [`DES_ROUND_W-1:0] round_t;

  localparam int IP_TAB [1:64] = '{
    58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
    62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
    57, 49, 41, 33, 25, 17,  9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
    61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7};

  localparam int FP_TAB [1:64] = '{
    40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
    38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
    36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
    34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41,  9, 49, 17, 57, 25};

  localparam int E_TAB [1:48] = '{
    32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
     8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
    16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
    24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1};

  localparam int P_TAB [1:32] = '{
    16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
     2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25};

  // parity bits 8, 16, ... 64 never appear
  localparam int PC1_TAB [1:56] = '{
    57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
    10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
    14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4};

  localparam int PC2_TAB [1:48] = '{
    14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
    23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
    41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
    44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32};

  // index is row * 16 + column
  localparam logic [3:0] SBOX_TAB [1:8][0:63] = '{
    '{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
       0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
       4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
      15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
    '{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
       3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
       0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
      13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
    '{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
      13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
      13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
       1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
    '{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
      13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
      10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
       3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
    '{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
      14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
       4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
      11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
    '{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
      10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
       9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
       4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
    '{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
      13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
       1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
       6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
    '{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
       1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
       7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
       2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}};

  // left rotation per encrypt round
  localparam logic [1:0] SHIFT_TAB [1:16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

endpackage

// ==== rtl/des_settings.svh ====
`ifndef DES_SETTINGS_SVH
`define DES_SETTINGS_SVH

// word sizes fixed by the standard
`define DES_BLOCK_W   64
`define DES_HALF_W    32
`define DES_KEY_W     64
`define DES_CD_W      28
`define DES_SUBKEY_W  48

// one round per clock
`define DES_ROUNDS    16
`define DES_ROUND_W   5

`endif
